// ==== dv/tinyCpuTb.sv ====
`timescale 1ns/1ps

module tinyCpuTb import cpuPkg::*; ;

    logic                 clk = 1'b0;
    logic                 rst = 1'b0;
    logic [AddrWidth-1:0] memAddr;
    logic [DataWidth-1:0] memWdata;
    logic [DataWidth-1:0] memRdata;
    logic [DataWidth-1:0] acc;
    logic                 memWe;
    logic                 halted;
    // copies image into mem on the first reset cycle
    logic                 loadImage = 1'b0;

    // 256 bytes of memory, program image and expected contents
    logic [7:0] mem [256];
    logic [7:0] image [256];
    logic [7:0] expMem [256];
    // first 16 writes of a run, in order
    logic [7:0] traceAddr [16];
    logic [7:0] traceData [16];
    int         traceCount = 0;
    logic [7:0] expTraceAddr [16];
    logic [7:0] expTraceData [16];
    int         expTraceCount = 0;
    int         writePtr = 0;

    int checkCount = 0;
    int errorCount = 0;
    int testCount = 0;
    int failingTests = 0;

    always #5 clk = ~clk;

    tinyCpu tinyCpu_i (
        .clk(clk),
        .rst(rst),
        .memAddr(memAddr),
        .memWdata(memWdata),
        .memWe(memWe),
        .memRdata(memRdata),
        .acc(acc),
        .halted(halted)
    );

    // combinational read, write on the rising edge
    assign memRdata = mem[memAddr];

    always @(posedge clk) begin
        if (loadImage) begin
            for (int i = 0; i < 256; i++)
                mem[i] <= image[i];
            traceCount <= 0;
        end else if (memWe) begin
            mem[memAddr] <= memWdata;
            if (traceCount < 16) begin
                traceAddr[traceCount] <= memAddr;
                traceData[traceCount] <= memWdata;
            end
            traceCount <= traceCount + 1;
        end
    end

    // opcode bytes, class in [7:6]
    function automatic logic [7:0] aluByte(addrMode_e mode, aluOp_e op);
        return {ClassAlu, mode, op};
    endfunction

    function automatic logic [7:0] storeByte(addrMode_e mode);
        return {ClassStore, mode, OpLda};
    endfunction

    // offset counts from the byte after the branch
    function automatic logic [7:0] branchByte(branchCond_e cond, int offset);
        return {ClassBranch, cond, 4'(offset)};
    endfunction

    function automatic logic [7:0] haltByte();
        return {ClassHalt, ModeImm, OpLda};
    endfunction

    // pattern differs for every address
    task automatic fillImage();
        for (int i = 0; i < 256; i++) begin
            image[i]  = 8'(i * 37 + 11);
            expMem[i] = 8'(i * 37 + 11);
        end
        writePtr      = 0;
        expTraceCount = 0;
    endtask

    task automatic poke(input logic [7:0] addr, input logic [7:0] data);
        image[addr]  = data;
        expMem[addr] = data;
    endtask

    task automatic addByte(input logic [7:0] data);
        poke(8'(writePtr), data);
        writePtr++;
    endtask

    task automatic addPair(input logic [7:0] opcode, input logic [7:0] arg);
        addByte(opcode);
        addByte(arg);
    endtask

    // store acc at addr only when cond holds
    task automatic storeIfCond(input branchCond_e cond, input logic [7:0] addr);
        addByte(branchByte(cond, 1));
        addByte(branchByte(CondAlways, 2));
        addPair(storeByte(ModeDirect), addr);
    endtask

    task automatic expectWrite(input logic [7:0] addr, input logic [7:0] data);
        expMem[addr] = data;
        if (expTraceCount < 16) begin
            expTraceAddr[expTraceCount] = addr;
            expTraceData[expTraceCount] = data;
        end
        expTraceCount++;
    endtask

    task automatic checkValue(input string testName, input string what,
                              input int expected, input int actual);
        checkCount++;
        if (expected != actual) begin
            errorCount++;
            $display("Mismatch in %s, %s: expected %0h, actual %0h",
                     testName, what, expected, actual);
        end
    endtask

    task automatic checkMemory(input string testName);
        for (int i = 0; i < 256; i++)
            checkValue(testName, $sformatf("mem[%02h]", i), expMem[i], mem[i]);
    endtask

    task automatic checkTrace(input string testName);
        int n;
        checkValue(testName, "write count", expTraceCount, traceCount);
        n = (traceCount < expTraceCount) ? traceCount : expTraceCount;
        for (int i = 0; i < n && i < 16; i++) begin
            checkValue(testName, $sformatf("write %0d address", i), expTraceAddr[i], traceAddr[i]);
            checkValue(testName, $sformatf("write %0d data", i), expTraceData[i], traceData[i]);
        end
    endtask

    // 16 reset cycles with the image loaded in the first, then wait for halt
    task automatic runProgram(input string testName, output logic done);
        int cycles;
        @(posedge clk);
        rst       <= 1'b0;
        loadImage <= 1'b1;
        @(posedge clk);
        loadImage <= 1'b0;
        repeat (15) @(posedge clk);
        rst <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!halted && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        done = halted;
        if (!done) begin
            errorCount++;
            $display("%s: timeout, the processor never halted within 200 cycles", testName);
        end
    endtask

    task automatic reportTest(input string testName, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("%s: ok", testName);
        end else begin
            failingTests++;
            $display("%s: %0d errors", testName, errorCount - errorsBefore);
        end
    endtask

    task automatic immediateAlu();
        string      name;
        int         errorsBefore;
        logic       done;
        logic [7:0] value;
        name         = "immediateAlu";
        errorsBefore = errorCount;
        fillImage();
        addPair(aluByte(ModeImm, OpLda), 8'h5A);
        addPair(aluByte(ModeImm, OpAdd), 8'h33);
        addPair(aluByte(ModeImm, OpAnd), 8'h0F);
        addPair(aluByte(ModeImm, OpOr), 8'h40);
        addPair(aluByte(ModeImm, OpXor), 8'h81);
        addPair(storeByte(ModeDirect), 8'h80);
        addByte(haltByte());
        value = 8'h5A + 8'h33;
        value = value & 8'h0F;
        value = value | 8'h40;
        value = value ^ 8'h81;
        expectWrite(8'h80, value);
        runProgram(name, done);
        if (done) begin
            checkMemory(name);
            checkValue(name, "acc", value, acc);
        end
        reportTest(name, errorsBefore);
    endtask

    task automatic addressingModes();
        string      name;
        int         errorsBefore;
        logic       done;
        logic [7:0] sum;
        name         = "addressingModes";
        errorsBefore = errorCount;
        fillImage();
        poke(8'h90, 8'h21);
        // pointers for the indirect add and store
        poke(8'h91, 8'hA0);
        poke(8'hA0, 8'h17);
        poke(8'h92, 8'hB0);
        addPair(aluByte(ModeDirect, OpLda), 8'h90);
        addPair(aluByte(ModeIndirect, OpAdd), 8'h91);
        addPair(storeByte(ModeIndirect), 8'h92);
        addPair(aluByte(ModeImm, OpXor), 8'hFF);
        addPair(storeByte(ModeDirect), 8'hB1);
        addByte(haltByte());
        sum = image[8'h90] + image[image[8'h91]];
        expectWrite(image[8'h92], sum);
        expectWrite(8'hB1, sum ^ 8'hFF);
        runProgram(name, done);
        if (done) begin
            checkMemory(name);
            checkValue(name, "acc", sum ^ 8'hFF, acc);
        end
        reportTest(name, errorsBefore);
    endtask

    task automatic loopAndFlags();
        string      name;
        int         errorsBefore;
        int         loopStart;
        logic       done;
        logic [7:0] count;
        logic [7:0] value;
        logic       carry;
        name         = "loopAndFlags";
        errorsBefore = errorCount;
        fillImage();
        addPair(aluByte(ModeImm, OpLda), 8'h04);
        loopStart = writePtr;
        addPair(aluByte(ModeImm, OpSub), 8'h01);
        addPair(storeByte(ModeDirect), 8'hD0);
        // zero skips the back branch
        addByte(branchByte(CondZero, 1));
        addByte(branchByte(CondAlways, loopStart - (writePtr + 1)));
        addPair(aluByte(ModeImm, OpSub), 8'h01);
        addByte(branchByte(CondCarry, 2));
        addPair(storeByte(ModeDirect), 8'hD1);
        addByte(branchByte(CondNeg, 2));
        addPair(storeByte(ModeDirect), 8'hD2);
        addByte(haltByte());
        // one store per pass until the counter reaches zero
        count = 8'h04;
        do begin
            count = count - 8'h01;
            expectWrite(8'hD0, count);
        end while (count != 8'h00);
        value = count - 8'h01;
        carry = (count >= 8'h01);
        if (!carry)
            expectWrite(8'hD1, value);
        if (!value[7])
            expectWrite(8'hD2, value);
        runProgram(name, done);
        if (done) begin
            checkTrace(name);
            checkMemory(name);
            checkValue(name, "acc", value, acc);
        end
        reportTest(name, errorsBefore);
    endtask

    task automatic impliedAndCompare();
        string      name;
        int         errorsBefore;
        logic       done;
        logic [7:0] shifted;
        logic [7:0] halved;
        name         = "impliedAndCompare";
        errorsBefore = errorCount;
        fillImage();
        addPair(aluByte(ModeImm, OpLda), 8'h81);
        addByte(aluByte(ModeImplied, OpShl));
        storeIfCond(CondCarry, 8'hC8);
        addByte(aluByte(ModeImplied, OpShr));
        storeIfCond(CondCarry, 8'hC9);
        addPair(aluByte(ModeImm, OpCmp), 8'h01);
        storeIfCond(CondZero, 8'hCA);
        addByte(haltByte());
        shifted = {7'h01, 1'b0};
        if (8'h81 >> 7)
            expectWrite(8'hC8, shifted);
        halved = shifted >> 1;
        if (shifted[0])
            expectWrite(8'hC9, halved);
        // acc kept by the compare, zero from acc minus 1
        if (halved == 8'h01)
            expectWrite(8'hCA, halved);
        runProgram(name, done);
        if (done) begin
            checkMemory(name);
            checkValue(name, "acc", halved, acc);
        end
        reportTest(name, errorsBefore);
    endtask

    task automatic randomArithmetic();
        string      name;
        string      runName;
        int         errorsBefore;
        logic       done;
        logic [7:0] a;
        logic [7:0] b;
        logic       doSub;
        logic [8:0] wide;
        logic [7:0] value;
        logic       carry;
        name         = "randomArithmetic";
        errorsBefore = errorCount;
        for (int n = 0; n < 20; n++) begin
            a       = 8'($urandom());
            b       = 8'($urandom());
            doSub   = 1'($urandom());
            runName = $sformatf("%s run %0d", name, n);
            fillImage();
            addPair(aluByte(ModeImm, OpLda), a);
            addPair(doSub ? aluByte(ModeImm, OpSub) : aluByte(ModeImm, OpAdd), b);
            addPair(storeByte(ModeDirect), 8'hE0);
            // carry set falls into the marker load and store
            addByte(branchByte(CondCarry, 1));
            addByte(branchByte(CondAlways, 4));
            addPair(aluByte(ModeImm, OpLda), 8'hC3);
            addPair(storeByte(ModeDirect), 8'hE1);
            addByte(haltByte());
            if (doSub) begin
                value = a - b;
                carry = (a >= b);
            end else begin
                wide  = {1'b0, a} + {1'b0, b};
                value = wide[7:0];
                carry = wide[8];
            end
            expectWrite(8'hE0, value);
            if (carry)
                expectWrite(8'hE1, 8'hC3);
            runProgram(runName, done);
            if (done) begin
                checkMemory(runName);
                checkValue(runName, "acc", carry ? 8'hC3 : value, acc);
            end
        end
        reportTest(name, errorsBefore);
    endtask

    task automatic haltAndReset();
        string      name;
        int         errorsBefore;
        int         strobes;
        int         accMoves;
        logic       done;
        logic [7:0] sum;
        name         = "haltAndReset";
        errorsBefore = errorCount;
        strobes      = 0;
        accMoves     = 0;
        fillImage();
        addPair(aluByte(ModeImm, OpLda), 8'h3C);
        addPair(aluByte(ModeImm, OpAdd), 8'h19);
        addPair(storeByte(ModeDirect), 8'hF8);
        addByte(haltByte());
        sum = 8'h3C + 8'h19;
        expectWrite(8'hF8, sum);
        runProgram(name, done);
        if (done) begin
            checkMemory(name);
            checkValue(name, "acc", sum, acc);
            for (int i = 0; i < 50; i++) begin
                @(negedge clk);
                if (memWe)
                    strobes++;
                if (acc != sum)
                    accMoves++;
            end
            checkValue(name, "write strobes while halted", 0, strobes);
            checkValue(name, "cycles with acc moved", 0, accMoves);
            checkMemory(name);
            // reload puts the fill byte back at F8, so the store must repeat
            runProgram(name, done);
            if (done) begin
                checkMemory(name);
                checkValue(name, "acc after second reset", sum, acc);
            end
        end
        reportTest(name, errorsBefore);
    endtask

    initial begin
        void'($urandom(81));
        immediateAlu();
        addressingModes();
        loopAndFlags();
        impliedAndCompare();
        randomArithmetic();
        haltAndReset();
        $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
                 testCount, failingTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
verilog/cpuPkg.sv
verilog/timingGenerator.sv
verilog/instrDecode.sv
verilog/addressUnit.sv
verilog/executeUnit.sv
verilog/resultUnit.sv
verilog/tinyCpu.sv
dv/tinyCpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tinyCpuTb -f files.f -o tinyCpuSim
./obj_dir/tinyCpuSim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation log is clean"

// ==== verilog/addressUnit.sv ====
`timescale 1ns/1ps

module addressUnit import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  decodedInstr_t        dec,
    input  phaseStep_t           step,
    input  logic [DataWidth-1:0] memRdata,
    input  logic                 branchTaken,
    input  logic [AddrWidth-1:0] branchTarget,
    output logic [AddrWidth-1:0] memAddr,
    output logic [DataWidth-1:0] operand,
    output logic [AddrWidth-1:0] effAddr,
    output logic [AddrWidth-1:0] pc
);

    instrWord_u fetched;
    logic       addrActive;
    logic       lastAddrStep;
    logic       storeWrite;
    logic       fetching;

    assign fetched = memRdata;

    // reset word runs an addressing step but reads nothing
    assign addrActive   = step.isAddressing && (dec.instrClass != ClassHalt);
    assign lastAddrStep = (step.timeOut == dec.addressTimingCode);
    assign storeWrite   = dec.isStore && !step.isAddressing && (step.timeOut == 3'd0);
    assign fetching     = isFetchStep(dec, step);

    // first addressing step reads at pc, later ones follow effAddr
    assign memAddr = ((step.isAddressing && step.timeOut != 3'd0) || storeWrite) ? effAddr : pc;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= '0;
        end else if (addrActive && step.timeOut == 3'd0) begin
            pc <= pc + 1'b1;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (fetching && fetched.alu.instrClass != ClassHalt) begin
            // halt keeps pc on itself
            pc <= pc + 1'b1;
        end
    end

    // pointer and address bytes go to effAddr, last byte is the operand
    always_ff @(posedge clk) begin
        if (addrActive) begin
            if (lastAddrStep)
                operand <= memRdata;
            else
                effAddr <= memRdata;
        end
    end

endmodule

// ==== verilog/cpuPkg.sv ====
package cpuPkg;

    localparam int DataWidth = 8;
    localparam int AddrWidth = 8;

    typedef enum logic [1:0] {
        ClassAlu    = 2'b00,
        ClassStore  = 2'b01,
        ClassBranch = 2'b10,
        ClassHalt   = 2'b11
    } instrClass_e;

    typedef enum logic [1:0] {
        ModeImm      = 2'b00,
        ModeDirect   = 2'b01,
        ModeIndirect = 2'b10,
        ModeImplied  = 2'b11
    } addrMode_e;

    typedef enum logic [3:0] {
        OpLda = 4'd0,
        OpAdd = 4'd1,
        OpSub = 4'd2,
        OpAnd = 4'd3,
        OpOr  = 4'd4,
        OpXor = 4'd5,
        OpCmp = 4'd6,
        OpShl = 4'd7,
        OpShr = 4'd8
    } aluOp_e;

    typedef enum logic [1:0] {CondAlways, CondZero, CondCarry, CondNeg} branchCond_e;

    // opcode byte, alu and store form
    typedef struct packed {
        instrClass_e instrClass;
        addrMode_e   mode;
        aluOp_e      aluOp;
    } aluForm_t;

    // opcode byte, branch form with pc-relative offset
    typedef struct packed {
        instrClass_e       instrClass;
        branchCond_e       cond;
        logic signed [3:0] offset;
    } branchForm_t;

    typedef union packed {
        aluForm_t    alu;
        branchForm_t branch;
    } instrWord_u;

    // phase lengths, code N means N+1 steps
    localparam logic [2:0] AddrCodeImm      = 3'd0;
    localparam logic [2:0] AddrCodeDirect   = 3'd1;
    localparam logic [2:0] AddrCodeIndirect = 3'd2;
    localparam logic [2:0] OpCodeAlu        = 3'd0;
    localparam logic [2:0] OpCodeStore      = 3'd1;
    localparam logic [2:0] OpCodeBranch     = 3'd1;
    localparam logic [2:0] OpCodeHalt       = 3'd0;

    // halt class with a single immediate-length addressing step
    localparam logic [DataWidth-1:0] ResetWord = {ClassHalt, ModeImm, OpLda};

    typedef struct packed {
        instrClass_e       instrClass;
        addrMode_e         mode;
        aluOp_e            aluOp;
        branchCond_e       cond;
        logic signed [3:0] offset;
        logic [2:0]        addressTimingCode;
        logic [2:0]        opTimingCode;
        logic              passAddressing;
        logic              isStore;
        logic              isHalt;
    } decodedInstr_t;

    typedef struct packed {
        logic       isAddressing;
        logic [2:0] timeOut;
    } phaseStep_t;

    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
    } flags_t;

    typedef struct packed {
        logic [DataWidth-1:0] value;
        flags_t               flags;
        logic                 writesAcc;
        logic                 writesFlags;
    } aluResult_t;

    // operation length of the instruction held in the register
    function automatic logic [2:0] opCodeOf(decodedInstr_t d);
        if (d.isStore)
            return OpCodeStore;
        case (d.instrClass)
            ClassBranch: return OpCodeBranch;
            ClassHalt: return OpCodeHalt;
            default: return OpCodeAlu;
        endcase
    endfunction

    // last operation step, which also fetches the next opcode
    function automatic logic isFetchStep(decodedInstr_t d, phaseStep_t s);
        return !s.isAddressing && (s.timeOut == opCodeOf(d));
    endfunction

endpackage

// ==== verilog/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit import cpuPkg::*; (
    input  decodedInstr_t        dec,
    input  phaseStep_t           step,
    input  logic [DataWidth-1:0] operand,
    input  logic [AddrWidth-1:0] pc,
    input  logic [DataWidth-1:0] acc,
    input  flags_t               flags,
    output aluResult_t           result,
    output logic                 branchTaken,
    output logic [AddrWidth-1:0] branchTarget
);

    // extra bit catches carry or borrow
    logic [DataWidth:0] wide;
    logic               condMet;

    always_comb begin
        wide               = {1'b0, acc} - {1'b0, operand};
        result.value       = acc;
        result.flags       = flags;
        result.writesAcc   = (dec.instrClass == ClassAlu);
        result.writesFlags = (dec.instrClass == ClassAlu);
        case (dec.aluOp)
            OpLda: result.value = operand;
            OpAdd: begin
                wide               = {1'b0, acc} + {1'b0, operand};
                result.value       = wide[DataWidth-1:0];
                result.flags.carry = wide[DataWidth];
            end
            OpSub, OpCmp: begin
                // carry means no borrow
                result.value       = wide[DataWidth-1:0];
                result.flags.carry = !wide[DataWidth];
            end
            OpAnd: result.value = acc & operand;
            OpOr: result.value = acc | operand;
            OpXor: result.value = acc ^ operand;
            OpShl: begin
                result.value       = {acc[DataWidth-2:0], 1'b0};
                result.flags.carry = acc[DataWidth-1];
            end
            OpShr: begin
                result.value       = {1'b0, acc[DataWidth-1:1]};
                result.flags.carry = acc[0];
            end
            default: begin
                result.writesAcc   = 1'b0;
                result.writesFlags = 1'b0;
            end
        endcase
        // compare only updates flags
        if (dec.aluOp == OpCmp)
            result.writesAcc = 1'b0;
        result.flags.zero     = (result.value == '0);
        result.flags.negative = result.value[DataWidth-1];
    end

    always_comb begin
        case (dec.cond)
            CondZero: condMet = flags.zero;
            CondCarry: condMet = flags.carry;
            CondNeg: condMet = flags.negative;
            default: condMet = 1'b1;
        endcase
    end

    // pc already points past the branch opcode
    assign branchTarget = pc + {{(AddrWidth - 4){dec.offset[3]}}, dec.offset};
    assign branchTaken  = condMet && (dec.instrClass == ClassBranch)
                          && !step.isAddressing && (step.timeOut == 3'd0);

endmodule

// ==== verilog/instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  phaseStep_t           step,
    input  logic [DataWidth-1:0] memRdata,
    output decodedInstr_t        dec,
    output logic                 halted
);

    instrWord_u    ir;
    // low while the reset word sits in ir
    logic          irValid;
    decodedInstr_t irDec;
    decodedInstr_t fetchDec;
    logic          fetching;

    function automatic logic [2:0] addrCodeOf(addrMode_e mode);
        case (mode)
            ModeDirect: return AddrCodeDirect;
            ModeIndirect: return AddrCodeIndirect;
            default: return AddrCodeImm;
        endcase
    endfunction

    function automatic decodedInstr_t decode(instrWord_u w);
        decodedInstr_t d;
        d            = '0;
        d.instrClass = w.alu.instrClass;
        d.mode       = w.alu.mode;
        d.aluOp      = w.alu.aluOp;
        d.cond       = w.branch.cond;
        d.offset     = w.branch.offset;
        case (w.alu.instrClass)
            ClassAlu: begin
                d.passAddressing    = (w.alu.mode == ModeImplied);
                d.addressTimingCode = addrCodeOf(w.alu.mode);
            end
            ClassStore: begin
                // only memory modes give a target, others fall through as no-op
                d.isStore           = (w.alu.mode inside {ModeDirect, ModeIndirect});
                d.passAddressing    = !d.isStore;
                d.addressTimingCode = addrCodeOf(w.alu.mode);
            end
            ClassBranch: d.passAddressing = 1'b1;
            default: begin
                d.passAddressing = 1'b1;
                d.isHalt         = 1'b1;
            end
        endcase
        d.opTimingCode = opCodeOf(d);
        return d;
    endfunction

    always_comb begin
        irDec = decode(ir);
        if (!irValid) begin
            // reset word gets its addressing step, then a plain fetch
            irDec.isHalt         = 1'b0;
            irDec.passAddressing = 1'b0;
        end
    end

    assign fetchDec = decode(memRdata);
    assign fetching = isFetchStep(irDec, step);

    // timing fields switch to the incoming opcode during fetch
    always_comb begin
        dec = irDec;
        if (fetching) begin
            dec.addressTimingCode = fetchDec.addressTimingCode;
            dec.opTimingCode      = fetchDec.opTimingCode;
            dec.passAddressing    = fetchDec.passAddressing;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ir      <= ResetWord;
            irValid <= 1'b0;
        end else if (fetching) begin
            ir      <= memRdata;
            irValid <= 1'b1;
        end
    end

    assign halted = irDec.isHalt;

    // fetched bytes from memory must be clean
    assert property (@(posedge clk) disable iff (!rst) !$isunknown(dec));

endmodule

// ==== verilog/resultUnit.sv ====
`timescale 1ns/1ps

module resultUnit import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  decodedInstr_t        dec,
    input  phaseStep_t           step,
    input  aluResult_t           result,
    input  logic [AddrWidth-1:0] effAddr,
    output logic                 memWe,
    output logic [DataWidth-1:0] memWdata,
    output logic [DataWidth-1:0] acc,
    output flags_t               flags
);

    logic commit;

    // alu ops retire on the edge closing their fetch step
    assign commit = (dec.instrClass == ClassAlu) && isFetchStep(dec, step);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            acc   <= '0;
            flags <= '0;
        end else if (commit) begin
            if (result.writesAcc)
                acc <= result.value;
            if (result.writesFlags)
                flags <= result.flags;
        end
    end

    // store writes on the first operation step
    assign memWe    = dec.isStore && !step.isAddressing && (step.timeOut == 3'd0);
    assign memWdata = acc;

    // write follows addressing directly and its target settled a cycle earlier
    assert property (@(posedge clk) disable iff (!rst)
        memWe |-> $past(step.isAddressing) && $stable(effAddr));

endmodule

// ==== verilog/timingGenerator.sv ====
`timescale 1ns/1ps

module timingGenerator import cpuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       passAddressing,
    input  logic [2:0] addressTimingCode,
    input  logic [2:0] opTimingCode,
    output phaseStep_t step
);

    // steps left in the phase, zero on its last step
    logic [2:0] negTime;
    logic [2:0] nextTime;
    logic [2:0] stepCnt;
    logic       isAddressing;
    logic       phaseEnd;

    assign phaseEnd = (negTime == 3'd0);

    always_comb begin
        if (!phaseEnd)
            nextTime = negTime - 3'd1;
        // codes here already belong to the next instruction on a fetch step
        else if (isAddressing || passAddressing)
            nextTime = opTimingCode;
        else
            nextTime = addressTimingCode;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            // reset word runs one addressing step
            negTime      <= AddrCodeImm;
            stepCnt      <= 3'd0;
            isAddressing <= 1'b1;
        end else begin
            negTime <= nextTime;
            stepCnt <= phaseEnd ? 3'd0 : stepCnt + 3'd1;
            if (passAddressing)
                isAddressing <= 1'b0;
            else if (phaseEnd)
                isAddressing <= !isAddressing;
        end
    end

    assign step.isAddressing = isAddressing;
    assign step.timeOut      = stepCnt;

    // counting step stays inside the code decoded for the active phase
    assert property (@(posedge clk) disable iff (!rst)
        (isAddressing || !phaseEnd)
            |-> stepCnt <= (isAddressing ? addressTimingCode : opTimingCode));

endmodule

// ==== verilog/tinyCpu.sv ====
`timescale 1ns/1ps

module tinyCpu import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    output logic [AddrWidth-1:0] memAddr,
    output logic [DataWidth-1:0] memWdata,
    output logic                 memWe,
    input  logic [DataWidth-1:0] memRdata,
    output logic [DataWidth-1:0] acc,
    output logic                 halted
);

    decodedInstr_t        dec;
    phaseStep_t           step;
    aluResult_t           aluOut;
    flags_t               flags;
    logic [DataWidth-1:0] operand;
    logic [AddrWidth-1:0] effAddr;
    logic [AddrWidth-1:0] pc;
    logic [AddrWidth-1:0] branchTarget;
    logic                 branchTaken;

    instrDecode decode (
        .clk(clk),
        .rst(rst),
        .step(step),
        .memRdata(memRdata),
        .dec(dec),
        .halted(halted)
    );

    // codes and passAddressing come straight from decode
    timingGenerator timing (
        .clk(clk),
        .rst(rst),
        .passAddressing(dec.passAddressing),
        .addressTimingCode(dec.addressTimingCode),
        .opTimingCode(dec.opTimingCode),
        .step(step)
    );

    addressUnit addressing (
        .clk(clk),
        .rst(rst),
        .dec(dec),
        .step(step),
        .memRdata(memRdata),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .memAddr(memAddr),
        .operand(operand),
        .effAddr(effAddr),
        .pc(pc)
    );

    executeUnit execute (
        .dec(dec),
        .step(step),
        .operand(operand),
        .pc(pc),
        .acc(acc),
        .flags(flags),
        .result(aluOut),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

    resultUnit result (
        .clk(clk),
        .rst(rst),
        .dec(dec),
        .step(step),
        .result(aluOut),
        .effAddr(effAddr),
        .memWe(memWe),
        .memWdata(memWdata),
        .acc(acc),
        .flags(flags)
    );

endmodule
